/* tb.f */
source/lrsc_pkg.sv
source/lrsc_fifo.sv
source/lrsc_res_table.sv
source/lrsc_read_path.sv
source/lrsc_write_path.sv
source/lrsc_write_resp.sv
source/lrsc_adapter.sv
tb/lrsc_mem_model.sv
tb/tb_lrsc.sv

/* tb/tb_lrsc.sv */
/*
 * Testbench of the LR/SC adapter with the window 0x1000 to 0x1FFF.
 * Rows run one at a time, except burst rows, which are writes issued
 * back to back. Upstream response ready toggles once a burst has started.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_lrsc;

    localparam logic [31:0]     RAND_SEED = 32'h3d2a9d44;
    localparam lrsc_pkg::resp_e OK        = lrsc_pkg::RESP_OKAY;
    localparam lrsc_pkg::resp_e EX        = lrsc_pkg::RESP_EXOKAY;

    typedef enum logic {OP_RD, OP_WR} op_e;

    typedef struct {
        op_e               op;
        logic              lock;
        lrsc_pkg::id_t     id;
        lrsc_pkg::addr_t   addr;
        lrsc_pkg::data_t   data;
        lrsc_pkg::resp_e   exp_resp;
        lrsc_pkg::data_t   exp_data;
        logic              burst;
    } row_t;

    logic              clk_i;
    logic              rst_ni;
    lrsc_pkg::rd_req_t up_rd_req_i;
    logic              up_rd_valid_i;
    logic              up_rd_ready_o;
    lrsc_pkg::wr_req_t up_wr_req_i;
    logic              up_wr_valid_i;
    logic              up_wr_ready_o;
    lrsc_pkg::rd_rsp_t up_rd_rsp_o;
    logic              up_rd_rsp_valid_o;
    logic              up_rd_rsp_ready_i;
    lrsc_pkg::wr_rsp_t up_wr_rsp_o;
    logic              up_wr_rsp_valid_o;
    logic              up_wr_rsp_ready_i;
    lrsc_pkg::rd_req_t dn_rd_req;
    logic              dn_rd_valid;
    logic              dn_rd_ready;
    lrsc_pkg::wr_req_t dn_wr_req;
    logic              dn_wr_valid;
    logic              dn_wr_ready;
    lrsc_pkg::rd_rsp_t dn_rd_rsp;
    logic              dn_rd_rsp_valid;
    logic              dn_rd_rsp_ready;
    lrsc_pkg::wr_rsp_t dn_wr_rsp;
    logic              dn_wr_rsp_valid;
    logic              dn_wr_rsp_ready;

    row_t rows [$];
    int   num_rows     = 0;
    logic toggle_ready = 1'b0;

    lrsc_adapter #(
        .EXCL_BEGIN     (32'h0000_1000),
        .EXCL_END       (32'h0000_1FFF),
        .MAX_READ_TXNS  (4),
        .MAX_WRITE_TXNS (4)
    ) DUT (
        .clk_i (clk_i), .rst_ni (rst_ni),
        .up_rd_req_i (up_rd_req_i), .up_rd_valid_i (up_rd_valid_i),
        .up_rd_ready_o (up_rd_ready_o),
        .up_wr_req_i (up_wr_req_i), .up_wr_valid_i (up_wr_valid_i),
        .up_wr_ready_o (up_wr_ready_o),
        .up_rd_rsp_o (up_rd_rsp_o), .up_rd_rsp_valid_o (up_rd_rsp_valid_o),
        .up_rd_rsp_ready_i (up_rd_rsp_ready_i),
        .up_wr_rsp_o (up_wr_rsp_o), .up_wr_rsp_valid_o (up_wr_rsp_valid_o),
        .up_wr_rsp_ready_i (up_wr_rsp_ready_i),
        .dn_rd_req_o (dn_rd_req), .dn_rd_valid_o (dn_rd_valid), .dn_rd_ready_i (dn_rd_ready),
        .dn_wr_req_o (dn_wr_req), .dn_wr_valid_o (dn_wr_valid), .dn_wr_ready_i (dn_wr_ready),
        .dn_rd_rsp_i (dn_rd_rsp), .dn_rd_rsp_valid_i (dn_rd_rsp_valid),
        .dn_rd_rsp_ready_o (dn_rd_rsp_ready),
        .dn_wr_rsp_i (dn_wr_rsp), .dn_wr_rsp_valid_i (dn_wr_rsp_valid),
        .dn_wr_rsp_ready_o (dn_wr_rsp_ready)
    );

    lrsc_mem_model u_mem (
        .clk_i (clk_i), .rst_ni (rst_ni),
        .rd_req_i (dn_rd_req), .rd_valid_i (dn_rd_valid), .rd_ready_o (dn_rd_ready),
        .wr_req_i (dn_wr_req), .wr_valid_i (dn_wr_valid), .wr_ready_o (dn_wr_ready),
        .rd_rsp_o (dn_rd_rsp), .rd_rsp_valid_o (dn_rd_rsp_valid),
        .rd_rsp_ready_i (dn_rd_rsp_ready),
        .wr_rsp_o (dn_wr_rsp), .wr_rsp_valid_o (dn_wr_rsp_valid),
        .wr_rsp_ready_i (dn_wr_rsp_ready)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        #1;
        up_rd_rsp_ready_i = toggle_ready ? 1'($urandom_range(1, 0)) : 1'b1;
        up_wr_rsp_ready_i = toggle_ready ? 1'($urandom_range(1, 0)) : 1'b1;
    end

    function automatic void add_row(input op_e op, input logic lock, input lrsc_pkg::id_t id,
                                    input lrsc_pkg::addr_t addr, input lrsc_pkg::data_t data,
                                    input lrsc_pkg::resp_e resp, input lrsc_pkg::data_t exp,
                                    input logic burst);
        row_t r;
        r = '{op, lock, id, addr, data, resp, exp, burst};
        rows.push_back(r);
    endfunction

    // Expected values follow from a zeroed memory and the rows' own writes
    function automatic void build_table();
        // Reservation, successful store, read-back
        add_row(OP_RD, 1'b1, 2'd0, 32'h1010, 32'h0,         EX, 32'h0,         1'b0);
        add_row(OP_WR, 1'b1, 2'd0, 32'h1010, 32'hA5A5_0001, EX, 32'h0,         1'b0);
        add_row(OP_RD, 1'b0, 2'd0, 32'h1010, 32'h0,         OK, 32'hA5A5_0001, 1'b0);
        // Stores without a reservation, the second one after it was used up
        add_row(OP_WR, 1'b1, 2'd1, 32'h1020, 32'hDEAD_0002, OK, 32'h0,         1'b0);
        add_row(OP_RD, 1'b0, 2'd1, 32'h1020, 32'h0,         OK, 32'h0,         1'b0);
        add_row(OP_WR, 1'b1, 2'd0, 32'h1010, 32'h1111_1111, OK, 32'h0,         1'b0);
        add_row(OP_RD, 1'b0, 2'd0, 32'h1010, 32'h0,         OK, 32'hA5A5_0001, 1'b0);
        // Another ID's plain write kills the reservation
        add_row(OP_RD, 1'b1, 2'd1, 32'h1040, 32'h0,         EX, 32'h0,         1'b0);
        add_row(OP_WR, 1'b0, 2'd2, 32'h1040, 32'h2222_0003, OK, 32'h0,         1'b0);
        add_row(OP_WR, 1'b1, 2'd1, 32'h1040, 32'h3333_0004, OK, 32'h0,         1'b0);
        add_row(OP_RD, 1'b0, 2'd3, 32'h1040, 32'h0,         OK, 32'h2222_0003, 1'b0);
        // Outside the window
        add_row(OP_RD, 1'b1, 2'd2, 32'h2000, 32'h0,         OK, 32'h0,         1'b0);
        add_row(OP_WR, 1'b0, 2'd3, 32'h2000, 32'h4444_0005, OK, 32'h0,         1'b0);
        add_row(OP_RD, 1'b0, 2'd3, 32'h2000, 32'h0,         OK, 32'h4444_0005, 1'b0);
        add_row(OP_WR, 1'b1, 2'd0, 32'h0800, 32'h5555_0006, OK, 32'h0,         1'b0);
        add_row(OP_RD, 1'b0, 2'd0, 32'h0800, 32'h0,         OK, 32'h5555_0006, 1'b0);
        // Pipelined stores under back-pressure, IDs 2 and 3 hold nothing
        add_row(OP_RD, 1'b1, 2'd0, 32'h1100, 32'h0,         EX, 32'h0,         1'b0);
        add_row(OP_RD, 1'b1, 2'd1, 32'h1104, 32'h0,         EX, 32'h0,         1'b0);
        add_row(OP_WR, 1'b1, 2'd0, 32'h1100, 32'h6666_0007, EX, 32'h0,         1'b1);
        add_row(OP_WR, 1'b1, 2'd2, 32'h1108, 32'h7777_0008, OK, 32'h0,         1'b1);
        add_row(OP_WR, 1'b1, 2'd1, 32'h1104, 32'h8888_0009, EX, 32'h0,         1'b1);
        add_row(OP_WR, 1'b1, 2'd3, 32'h110C, 32'h9999_000A, OK, 32'h0,         1'b1);
        add_row(OP_RD, 1'b0, 2'd0, 32'h1100, 32'h0,         OK, 32'h6666_0007, 1'b0);
        add_row(OP_RD, 1'b0, 2'd0, 32'h1108, 32'h0,         OK, 32'h0,         1'b0);
        add_row(OP_RD, 1'b0, 2'd1, 32'h1104, 32'h0,         OK, 32'h8888_0009, 1'b0);
        add_row(OP_RD, 1'b0, 2'd1, 32'h110C, 32'h0,         OK, 32'h0,         1'b0);
    endfunction

    task automatic fail_run(input string reason);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_rd_rsp(input int row, input lrsc_pkg::rd_rsp_t got,
                                input lrsc_pkg::rd_rsp_t exp);
        if (got !== exp) begin
            $display("[ERROR] up_rd_rsp_o (row %0d): got %h, expected %h", row, got, exp);
            fail_run("read response mismatch");
        end
    endtask

    task automatic check_wr_rsp(input int row, input lrsc_pkg::wr_rsp_t got,
                                input lrsc_pkg::wr_rsp_t exp);
        if (got !== exp) begin
            $display("[ERROR] up_wr_rsp_o (row %0d): got %h, expected %h", row, got, exp);
            fail_run("write response mismatch");
        end
    endtask

    task automatic check_dn_lock(input string name, input logic got);
        if (got !== 1'b0) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, 1'b0);
            fail_run("downstream request carries a lock");
        end
    endtask

    // The slave must never see a locked request
    always @(posedge clk_i) begin
        if (rst_ni && dn_rd_valid && dn_rd_ready) begin
            check_dn_lock("dn_rd_req_o.lock", dn_rd_req.lock);
        end
        if (rst_ni && dn_wr_valid && dn_wr_ready) begin
            check_dn_lock("dn_wr_req_o.lock", dn_wr_req.lock);
        end
    end

    // Request tasks start 1 ns after an edge and return 1 ns after the transfer edge
    task automatic send_rd(input row_t r);
        up_rd_req_i.addr = r.addr;
        up_rd_req_i.id   = r.id;
        up_rd_req_i.lock = r.lock;
        up_rd_valid_i    = 1'b1;
        do @(posedge clk_i); while (!up_rd_ready_o);
        #1;
        up_rd_valid_i = 1'b0;
    endtask

    task automatic send_wr(input row_t r);
        up_wr_req_i.addr = r.addr;
        up_wr_req_i.id   = r.id;
        up_wr_req_i.lock = r.lock;
        up_wr_req_i.data = r.data;
        up_wr_req_i.strb = '1;
        up_wr_valid_i    = 1'b1;
        do @(posedge clk_i); while (!up_wr_ready_o);
        #1;
        up_wr_valid_i = 1'b0;
    endtask

    task automatic wait_rd_rsp(input int row);
        lrsc_pkg::rd_rsp_t exp;
        exp = '{id: rows[row].id, data: rows[row].exp_data, resp: rows[row].exp_resp};
        do @(posedge clk_i); while (!(up_rd_rsp_valid_o && up_rd_rsp_ready_i));
        check_rd_rsp(row, up_rd_rsp_o, exp);
        #1;
    endtask

    task automatic wait_wr_rsp(input int row);
        lrsc_pkg::wr_rsp_t exp;
        exp = '{id: rows[row].id, resp: rows[row].exp_resp};
        do @(posedge clk_i); while (!(up_wr_rsp_valid_o && up_wr_rsp_ready_i));
        check_wr_rsp(row, up_wr_rsp_o, exp);
        #1;
    endtask

    task automatic single_row(input int row);
        if (rows[row].op == OP_RD) begin
            send_rd(rows[row]);
            wait_rd_rsp(row);
        end else begin
            send_wr(rows[row]);
            wait_wr_rsp(row);
        end
    endtask

    // Burst rows are writes, issued while earlier responses are still pending
    task automatic write_burst(input int first, input int last);
        fork
            for (int k = first; k <= last; k++) begin
                send_wr(rows[k]);
            end
            for (int k = first; k <= last; k++) begin
                wait_wr_rsp(k);
            end
        join
    endtask

    initial begin
        wait (num_rows > 0);
        repeat (num_rows * 50) @(posedge clk_i);
        $display("Timeout: the rows did not finish within %0d cycles", num_rows * 50);
        fail_run("watchdog expired");
    end

    initial begin
        int i;
        int last;
        clk_i             = 1'b0;
        rst_ni            = 1'b0;
        up_rd_req_i       = '0;
        up_rd_valid_i     = 1'b0;
        up_wr_req_i       = '0;
        up_wr_valid_i     = 1'b0;
        up_rd_rsp_ready_i = 1'b1;
        up_wr_rsp_ready_i = 1'b1;
        void'($urandom(RAND_SEED));
        build_table();
        num_rows = rows.size();
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        i = 0;
        while (i < num_rows) begin
            if (rows[i].burst) begin
                last = i;
                while ((last + 1 < num_rows) && rows[last + 1].burst) begin
                    last++;
                end
                toggle_ready = 1'b1;
                write_burst(i, last);
                i = last + 1;
            end else begin
                single_row(i);
                i++;
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/lrsc_mem_model.sv */
/*
 * In-order memory slave for the adapter testbench. Requests are always
 * accepted and a response waits 0 to 3 cycles before it is offered.
 * Memory reads as zero until written. Exclusive accesses are not modelled.
 */
`timescale 1ns/1ps
`default_nettype none

module lrsc_mem_model (
    input  wire                      clk_i,
    input  wire                      rst_ni,
    input  wire lrsc_pkg::rd_req_t   rd_req_i,
    input  wire                      rd_valid_i,
    output logic                     rd_ready_o,
    input  wire lrsc_pkg::wr_req_t   wr_req_i,
    input  wire                      wr_valid_i,
    output logic                     wr_ready_o,
    output lrsc_pkg::rd_rsp_t        rd_rsp_o,
    output logic                     rd_rsp_valid_o,
    input  wire                      rd_rsp_ready_i,
    output lrsc_pkg::wr_rsp_t        wr_rsp_o,
    output logic                     wr_rsp_valid_o,
    input  wire                      wr_rsp_ready_i
);

    lrsc_pkg::data_t   mem [lrsc_pkg::word_addr_t];
    lrsc_pkg::rd_rsp_t rd_q [$];
    lrsc_pkg::wr_rsp_t wr_q [$];
    int unsigned       rd_wait;
    int unsigned       wr_wait;

    initial begin
        rd_ready_o     = 1'b1;
        wr_ready_o     = 1'b1;
        rd_rsp_o       = '0;
        wr_rsp_o       = '0;
        rd_rsp_valid_o = 1'b0;
        wr_rsp_valid_o = 1'b0;
        rd_wait        = 0;
        wr_wait        = 0;
    end

    // Handshakes are sampled at the edge, outputs change 1 ns later
    always @(posedge clk_i) begin
        lrsc_pkg::rd_rsp_t    rrsp;
        lrsc_pkg::wr_rsp_t    wrsp;
        lrsc_pkg::word_addr_t word;
        lrsc_pkg::data_t      wdata;
        if (!rst_ni) begin
            rd_q.delete();
            wr_q.delete();
            rd_wait = 0;
            wr_wait = 0;
        end else begin
            if (rd_wait > 0) begin
                rd_wait--;
            end
            if (wr_wait > 0) begin
                wr_wait--;
            end
            if (rd_rsp_valid_o && rd_rsp_ready_i) begin
                void'(rd_q.pop_front());
                rd_wait = $urandom_range(3, 0);
            end
            if (wr_rsp_valid_o && wr_rsp_ready_i) begin
                void'(wr_q.pop_front());
                wr_wait = $urandom_range(3, 0);
            end
            if (rd_valid_i && rd_ready_o) begin
                word      = rd_req_i.addr[lrsc_pkg::ADDR_W-1:2];
                rrsp.id   = rd_req_i.id;
                rrsp.data = mem.exists(word) ? mem[word] : '0;
                rrsp.resp = lrsc_pkg::RESP_OKAY;
                rd_q.push_back(rrsp);
            end
            if (wr_valid_i && wr_ready_o) begin
                word  = wr_req_i.addr[lrsc_pkg::ADDR_W-1:2];
                wdata = mem.exists(word) ? mem[word] : '0;
                for (int b = 0; b < lrsc_pkg::STRB_W; b++) begin
                    if (wr_req_i.strb[b]) begin
                        wdata[8*b +: 8] = wr_req_i.data[8*b +: 8];
                    end
                end
                mem[word] = wdata;
                wrsp.id   = wr_req_i.id;
                wrsp.resp = lrsc_pkg::RESP_OKAY;
                wr_q.push_back(wrsp);
            end
        end
        #1;
        // Valid stays up until the head is taken, since the wait only restarts on a pop
        rd_rsp_valid_o = (rd_q.size() > 0) && (rd_wait == 0);
        wr_rsp_valid_o = (wr_q.size() > 0) && (wr_wait == 0);
        if (rd_q.size() > 0) begin
            rd_rsp_o = rd_q[0];
        end
        if (wr_q.size() > 0) begin
            wr_rsp_o = wr_q[0];
        end
    end

endmodule

`default_nettype wire

/* source/lrsc_adapter.sv */
/*
 * LR/SC adapter top. Adds exclusive access inside [EXCL_BEGIN, EXCL_END]
 * for a slave without it. Single-word accesses only. The slave must
 * answer each channel in request order.
 */
`timescale 1ns/1ps
`default_nettype none

module lrsc_adapter #(
    parameter lrsc_pkg::addr_t EXCL_BEGIN     = '0,
    parameter lrsc_pkg::addr_t EXCL_END       = '0,
    parameter int unsigned     MAX_READ_TXNS  = 4,
    parameter int unsigned     MAX_WRITE_TXNS = 4
) (
    input  wire                      clk_i,
    input  wire                      rst_ni,
    // Upstream master side
    input  wire lrsc_pkg::rd_req_t   up_rd_req_i,
    input  wire                      up_rd_valid_i,
    output logic                     up_rd_ready_o,
    input  wire lrsc_pkg::wr_req_t   up_wr_req_i,
    input  wire                      up_wr_valid_i,
    output logic                     up_wr_ready_o,
    output lrsc_pkg::rd_rsp_t        up_rd_rsp_o,
    output logic                     up_rd_rsp_valid_o,
    input  wire                      up_rd_rsp_ready_i,
    output lrsc_pkg::wr_rsp_t        up_wr_rsp_o,
    output logic                     up_wr_rsp_valid_o,
    input  wire                      up_wr_rsp_ready_i,
    // Downstream slave side
    output lrsc_pkg::rd_req_t        dn_rd_req_o,
    output logic                     dn_rd_valid_o,
    input  wire                      dn_rd_ready_i,
    output lrsc_pkg::wr_req_t        dn_wr_req_o,
    output logic                     dn_wr_valid_o,
    input  wire                      dn_wr_ready_i,
    input  wire lrsc_pkg::rd_rsp_t   dn_rd_rsp_i,
    input  wire                      dn_rd_rsp_valid_i,
    output logic                     dn_rd_rsp_ready_o,
    input  wire lrsc_pkg::wr_rsp_t   dn_wr_rsp_i,
    input  wire                      dn_wr_rsp_valid_i,
    output logic                     dn_wr_rsp_ready_o
);

    logic                 res_set;
    lrsc_pkg::id_t        res_set_id;
    lrsc_pkg::word_addr_t res_set_addr;
    lrsc_pkg::id_t        check_id;
    lrsc_pkg::word_addr_t check_addr;
    logic                 check_res;
    logic                 clear;
    lrsc_pkg::wr_status_t status;
    logic                 status_push;
    logic                 status_full;

    lrsc_read_path #(
        .EXCL_BEGIN    (EXCL_BEGIN),
        .EXCL_END      (EXCL_END),
        .MAX_READ_TXNS (MAX_READ_TXNS)
    ) u_read_path (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .up_rd_req_i       (up_rd_req_i),
        .up_rd_valid_i     (up_rd_valid_i),
        .up_rd_ready_o     (up_rd_ready_o),
        .dn_rd_req_o       (dn_rd_req_o),
        .dn_rd_valid_o     (dn_rd_valid_o),
        .dn_rd_ready_i     (dn_rd_ready_i),
        .dn_rd_rsp_i       (dn_rd_rsp_i),
        .dn_rd_rsp_valid_i (dn_rd_rsp_valid_i),
        .dn_rd_rsp_ready_o (dn_rd_rsp_ready_o),
        .up_rd_rsp_o       (up_rd_rsp_o),
        .up_rd_rsp_valid_o (up_rd_rsp_valid_o),
        .up_rd_rsp_ready_i (up_rd_rsp_ready_i),
        .res_set_o         (res_set),
        .res_set_id_o      (res_set_id),
        .res_set_addr_o    (res_set_addr)
    );

    lrsc_write_path #(
        .EXCL_BEGIN (EXCL_BEGIN),
        .EXCL_END   (EXCL_END)
    ) u_write_path (
        .up_wr_req_i   (up_wr_req_i),
        .up_wr_valid_i (up_wr_valid_i),
        .up_wr_ready_o (up_wr_ready_o),
        .dn_wr_req_o   (dn_wr_req_o),
        .dn_wr_valid_o (dn_wr_valid_o),
        .dn_wr_ready_i (dn_wr_ready_i),
        .check_id_o    (check_id),
        .check_addr_o  (check_addr),
        .check_res_i   (check_res),
        .clear_o       (clear),
        .status_o      (status),
        .status_push_o (status_push),
        .status_full_i (status_full)
    );

    lrsc_write_resp #(
        .MAX_WRITE_TXNS (MAX_WRITE_TXNS)
    ) u_write_resp (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .status_i          (status),
        .status_push_i     (status_push),
        .status_full_o     (status_full),
        .dn_wr_rsp_i       (dn_wr_rsp_i),
        .dn_wr_rsp_valid_i (dn_wr_rsp_valid_i),
        .dn_wr_rsp_ready_o (dn_wr_rsp_ready_o),
        .up_wr_rsp_o       (up_wr_rsp_o),
        .up_wr_rsp_valid_o (up_wr_rsp_valid_o),
        .up_wr_rsp_ready_i (up_wr_rsp_ready_i)
    );

    lrsc_res_table u_res_table (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .set_i        (res_set),
        .set_id_i     (res_set_id),
        .set_addr_i   (res_set_addr),
        .check_id_i   (check_id),
        .check_addr_i (check_addr),
        .check_res_o  (check_res),
        .clear_i      (clear)
    );

endmodule

`default_nettype wire

/* source/lrsc_write_resp.sv */
/*
 * Write response merge. The status FIFO head decides whether the next
 * upstream response is injected or taken from downstream. The slave must
 * answer writes in order. Responses leave through an output register.
 */
`timescale 1ns/1ps
`default_nettype none

module lrsc_write_resp #(
    parameter int unsigned MAX_WRITE_TXNS = 4
) (
    input  wire                        clk_i,
    input  wire                        rst_ni,
    input  wire lrsc_pkg::wr_status_t  status_i,
    input  wire                        status_push_i,
    output logic                       status_full_o,
    input  wire lrsc_pkg::wr_rsp_t     dn_wr_rsp_i,
    input  wire                        dn_wr_rsp_valid_i,
    output logic                       dn_wr_rsp_ready_o,
    output lrsc_pkg::wr_rsp_t          up_wr_rsp_o,
    output logic                       up_wr_rsp_valid_o,
    input  wire                        up_wr_rsp_ready_i
);

    lrsc_pkg::wr_status_t head;
    lrsc_pkg::wr_rsp_t    rsp_d;
    logic                 empty;
    logic                 take;
    logic                 reg_ready;

    lrsc_fifo #(
        .WIDTH ($bits(lrsc_pkg::wr_status_t)),
        .DEPTH (MAX_WRITE_TXNS)
    ) u_status_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (status_push_i),
        .data_i  (status_i),
        .full_o  (status_full_o),
        .pop_i   (take),
        .data_o  (head),
        .empty_o (empty)
    );

    assign reg_ready = !up_wr_rsp_valid_o || up_wr_rsp_ready_i;

    always_comb begin
        dn_wr_rsp_ready_o = 1'b0;
        take              = 1'b0;
        rsp_d             = dn_wr_rsp_i;
        if (!empty) begin
            if (head.status == lrsc_pkg::WR_INJECT) begin
                // Dropped write gets a plain OKAY
                rsp_d.id   = head.id;
                rsp_d.resp = lrsc_pkg::RESP_OKAY;
                take       = reg_ready;
            end else begin
                dn_wr_rsp_ready_o = reg_ready;
                take              = reg_ready && dn_wr_rsp_valid_i;
                if (!dn_wr_rsp_i.resp[1]) begin
                    rsp_d.resp = (head.status == lrsc_pkg::WR_EXCLUSIVE) ?
                                 lrsc_pkg::RESP_EXOKAY : lrsc_pkg::RESP_OKAY;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            up_wr_rsp_valid_o <= 1'b0;
        end else if (reg_ready) begin
            up_wr_rsp_valid_o <= take;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            up_wr_rsp_o <= rsp_d;
        end
    end

endmodule

`default_nettype wire

/* source/lrsc_write_path.sv */
/*
 * Write request decision of the LR/SC adapter. Purely combinational.
 * A failing exclusive write is accepted without a downstream request.
 * Every accepted write pushes one status record.
 */
`timescale 1ns/1ps
`default_nettype none

module lrsc_write_path #(
    parameter lrsc_pkg::addr_t EXCL_BEGIN = '0,
    parameter lrsc_pkg::addr_t EXCL_END   = '0
) (
    input  wire lrsc_pkg::wr_req_t   up_wr_req_i,
    input  wire                      up_wr_valid_i,
    output logic                     up_wr_ready_o,
    output lrsc_pkg::wr_req_t        dn_wr_req_o,
    output logic                     dn_wr_valid_o,
    input  wire                      dn_wr_ready_i,
    output lrsc_pkg::id_t            check_id_o,
    output lrsc_pkg::word_addr_t     check_addr_o,
    input  wire                      check_res_i,
    output logic                     clear_o,
    output lrsc_pkg::wr_status_t     status_o,
    output logic                     status_push_o,
    input  wire                      status_full_i
);

    logic in_window;
    logic excl;
    logic drop;
    logic accept;

    assign in_window = (up_wr_req_i.addr >= EXCL_BEGIN) && (up_wr_req_i.addr <= EXCL_END);
    assign excl      = in_window && up_wr_req_i.lock;

    assign check_id_o   = up_wr_req_i.id;
    assign check_addr_o = up_wr_req_i.addr[lrsc_pkg::ADDR_W-1:2];

    // Exclusive write that lost its reservation
    assign drop = excl && !check_res_i;

    always_comb begin
        dn_wr_req_o      = up_wr_req_i;
        dn_wr_req_o.lock = 1'b0;
    end

    assign dn_wr_valid_o = up_wr_valid_i && !status_full_i && !drop;
    assign up_wr_ready_o = !status_full_i && (drop || dn_wr_ready_i);
    assign accept        = up_wr_valid_i && up_wr_ready_o;

    // Any forwarded write in the window kills reservations on its word
    assign clear_o = accept && in_window && !drop;

    assign status_push_o = accept;
    assign status_o.id   = up_wr_req_i.id;

    always_comb begin
        if (drop) begin
            status_o.status = lrsc_pkg::WR_INJECT;
        end else if (excl) begin
            status_o.status = lrsc_pkg::WR_EXCLUSIVE;
        end else begin
            status_o.status = lrsc_pkg::WR_REGULAR;
        end
    end

endmodule

`default_nettype wire

/* source/lrsc_read_path.sv */
/*
 * Read channel of the LR/SC adapter. Requests pass straight through while
 * the in-flight record has room. The slave must answer reads in order.
 * Responses leave through an output register.
 */
`timescale 1ns/1ps
`default_nettype none

module lrsc_read_path #(
    parameter lrsc_pkg::addr_t EXCL_BEGIN    = '0,
    parameter lrsc_pkg::addr_t EXCL_END      = '0,
    parameter int unsigned     MAX_READ_TXNS = 4
) (
    input  wire                      clk_i,
    input  wire                      rst_ni,
    input  wire lrsc_pkg::rd_req_t   up_rd_req_i,
    input  wire                      up_rd_valid_i,
    output logic                     up_rd_ready_o,
    output lrsc_pkg::rd_req_t        dn_rd_req_o,
    output logic                     dn_rd_valid_o,
    input  wire                      dn_rd_ready_i,
    input  wire lrsc_pkg::rd_rsp_t   dn_rd_rsp_i,
    input  wire                      dn_rd_rsp_valid_i,
    output logic                     dn_rd_rsp_ready_o,
    output lrsc_pkg::rd_rsp_t        up_rd_rsp_o,
    output logic                     up_rd_rsp_valid_o,
    input  wire                      up_rd_rsp_ready_i,
    output logic                     res_set_o,
    output lrsc_pkg::id_t            res_set_id_o,
    output lrsc_pkg::word_addr_t     res_set_addr_o
);

    logic              excl;
    logic              accept;
    logic              fifo_full;
    logic              fifo_empty;
    logic              head_excl;
    logic              rsp_take;
    lrsc_pkg::rd_rsp_t rsp_d;

    assign excl = up_rd_req_i.lock && (up_rd_req_i.addr >= EXCL_BEGIN)
                  && (up_rd_req_i.addr <= EXCL_END);

    // Downstream never sees an exclusive access
    assign dn_rd_req_o.addr = up_rd_req_i.addr;
    assign dn_rd_req_o.id   = up_rd_req_i.id;
    assign dn_rd_req_o.lock = 1'b0;

    assign dn_rd_valid_o = up_rd_valid_i && !fifo_full;
    assign up_rd_ready_o = dn_rd_ready_i && !fifo_full;
    assign accept        = dn_rd_valid_o && dn_rd_ready_i;

    assign res_set_o      = accept && excl;
    assign res_set_id_o   = up_rd_req_i.id;
    assign res_set_addr_o = up_rd_req_i.addr[lrsc_pkg::ADDR_W-1:2];

    // One exclusive flag per outstanding read
    lrsc_fifo #(
        .WIDTH (1),
        .DEPTH (MAX_READ_TXNS)
    ) u_rd_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (accept),
        .data_i  (excl),
        .full_o  (fifo_full),
        .pop_i   (rsp_take),
        .data_o  (head_excl),
        .empty_o (fifo_empty)
    );

    assign dn_rd_rsp_ready_o = !up_rd_rsp_valid_o || up_rd_rsp_ready_i;
    assign rsp_take          = dn_rd_rsp_valid_i && dn_rd_rsp_ready_o && !fifo_empty;

    always_comb begin
        rsp_d = dn_rd_rsp_i;
        // Error responses keep their code
        if (!dn_rd_rsp_i.resp[1]) begin
            rsp_d.resp = head_excl ? lrsc_pkg::RESP_EXOKAY : lrsc_pkg::RESP_OKAY;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            up_rd_rsp_valid_o <= 1'b0;
        end else if (dn_rd_rsp_ready_o) begin
            up_rd_rsp_valid_o <= rsp_take;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_take) begin
            up_rd_rsp_o <= rsp_d;
        end
    end

endmodule

`default_nettype wire

/* source/lrsc_res_table.sv */
/*
 * Reservation table with one word reservation per ID.
 * The check is combinational. A clear drops every entry on the checked
 * word, then a same-cycle set writes its own entry.
 */
`timescale 1ns/1ps
`default_nettype none

module lrsc_res_table (
    input  wire                        clk_i,
    input  wire                        rst_ni,
    input  wire                        set_i,
    input  wire lrsc_pkg::id_t         set_id_i,
    input  wire lrsc_pkg::word_addr_t  set_addr_i,
    input  wire lrsc_pkg::id_t         check_id_i,
    input  wire lrsc_pkg::word_addr_t  check_addr_i,
    output logic                       check_res_o,
    input  wire                        clear_i
);

    localparam int unsigned N_IDS = 2 ** lrsc_pkg::ID_W;

    logic [N_IDS-1:0]     valid_q;
    logic [N_IDS-1:0]     valid_d;
    logic [N_IDS-1:0]     match;
    lrsc_pkg::word_addr_t addr_q [N_IDS];

    // Entries that hold a reservation on the checked word
    always_comb begin
        for (int i = 0; i < N_IDS; i++) begin
            match[i] = valid_q[i] && (addr_q[i] == check_addr_i);
        end
    end

    assign check_res_o = match[check_id_i];

    always_comb begin
        valid_d = valid_q;
        if (clear_i) begin
            valid_d = valid_d & ~match;
        end
        // Set wins over the clear
        if (set_i) begin
            valid_d[set_id_i] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (set_i) begin
            addr_q[set_id_i] <= set_addr_i;
        end
    end

endmodule

`default_nettype wire

/* source/lrsc_fifo.sv */
/*
 * Synchronous FIFO, not fall-through. Pushes while full and pops while
 * empty are ignored. Storage has no reset.
 */
`timescale 1ns/1ps
`default_nettype none

module lrsc_fifo #(
    parameter int unsigned WIDTH = 8,
    parameter int unsigned DEPTH = 4
) (
    input  wire              clk_i,
    input  wire              rst_ni,
    input  wire              push_i,
    input  wire [WIDTH-1:0]  data_i,
    output logic             full_o,
    input  wire              pop_i,
    output logic [WIDTH-1:0] data_o,
    output logic             empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

/* source/lrsc_pkg.sv */
/*
 * Shared widths, encodings and channel structs of the LR/SC adapter.
 * Widths are fixed here. Reservations are tracked per 32-bit word.
 * Bursts and sideband fields are not carried.
 */
`default_nettype none

package lrsc_pkg;

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned ID_W   = 2;
    localparam int unsigned STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ADDR_W-3:0] word_addr_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [DATA_W-1:0] data_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // What to do with the write response once its turn comes
    typedef enum logic [1:0] {
        WR_REGULAR   = 2'd0,
        WR_EXCLUSIVE = 2'd1,
        WR_INJECT    = 2'd2
    } wr_status_e;

    typedef struct packed {
        addr_t addr;
        id_t   id;
        logic  lock;
    } rd_req_t;

    typedef struct packed {
        addr_t             addr;
        id_t               id;
        logic              lock;
        data_t             data;
        logic [STRB_W-1:0] strb;
    } wr_req_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        resp_e resp;
    } rd_rsp_t;

    typedef struct packed {
        id_t   id;
        resp_e resp;
    } wr_rsp_t;

    typedef struct packed {
        wr_status_e status;
        id_t        id;
    } wr_status_t;

endpackage

`default_nettype wire
